//--- logic/motion_pkg.sv
`default_nettype none

package motion_pkg;

  // Widths shared across the design
  localparam int WORD_W  = 64;
  localparam int CMD_W   = 8;
  localparam int DIV_W   = 8;
  localparam int COUNT_W = 64;

  typedef logic [WORD_W-1:0] word_t;  // One SPI frame

  // Command header, bits 63:56 of the first word
  typedef logic [CMD_W-1:0] cmd_t;

  localparam cmd_t CMD_COORDINATED_STEP = 8'h01;
  localparam cmd_t CMD_MOTOR_ENABLE     = 8'h0a;
  localparam cmd_t CMD_CLK_DIVISOR      = 8'h0b;
  localparam cmd_t CMD_MICROSTEPS       = 8'h0c;
  localparam cmd_t CMD_API_VERSION      = 8'hfe;

  // Reported in reply bits 23:0
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

  // One full step in 32.32 fixed point
  localparam logic signed [63:0] STEP_ONE = 64'sh0000_0001_0000_0000;

  // Queued move record
  typedef struct packed {
    logic               dir;
    logic [63:0]        duration;   // Ticks minus one
    logic signed [63:0] increment;  // Velocity, 32.32
    logic signed [63:0] accel;      // Added to increment each tick
  } move_t;

  typedef enum logic [0:0] {
    FULL_STEP = 1'b0,
    HALF_STEP = 1'b1
  } step_mode_t;

endpackage

`default_nettype wire

//--- logic/move_if.sv
`timescale 1ns/1ps
`default_nettype none

interface move_if #(
  parameter int MOVE_DEPTH = 4
) ();
  import motion_pkg::*;

  logic                        push;       // One cycle, only while not full
  move_t                       push_move;
  logic                        full;
  logic                        pop;        // One cycle, only while not empty
  move_t                       head;
  logic                        empty;
  logic [$clog2(MOVE_DEPTH):0] level;      // Entries held

  modport producer (output push, output push_move, input full);
  modport store (
    input push, input push_move, input pop,
    output full, output head, output empty, output level
  );
  modport consumer (output pop, input head, input empty);

endinterface

`default_nettype wire

//--- logic/spi_word_port.sv
`timescale 1ns/1ps
`default_nettype none

module spi_word_port #(
  parameter int SYNC_STAGES = 2
) (
  input  wire logic              CLK,
  input  wire logic              rst,
  input  wire logic              sck,
  input  wire logic              cs,
  input  wire logic              copi,
  output logic                   cipo,
  output motion_pkg::word_t      word_rx,
  output logic                   word_strobe,
  input  wire motion_pkg::word_t word_tx
);
  import motion_pkg::*;

  logic [SYNC_STAGES-1:0] sck_sync;
  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] copi_sync;
  logic                   sck_q;
  logic                   cs_q;
  logic                   sck_rise;
  logic                   sck_fall;
  logic                   cs_rise;
  logic                   cs_fall;
  word_t                  rx_reg;
  word_t                  tx_reg;

  // Bring the pins into CLK, keep last value for edge detect
  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_sync  <= '0;
      cs_sync   <= '1;   // Bus idle
      copi_sync <= '0;
      sck_q     <= 1'b0;
      cs_q      <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], sck};
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs};
      copi_sync <= {copi_sync[SYNC_STAGES-2:0], copi};
      sck_q     <= sck_sync[SYNC_STAGES-1];
      cs_q      <= cs_sync[SYNC_STAGES-1];
    end
  end

  assign sck_rise = sck_sync[SYNC_STAGES-1] & ~sck_q;
  assign sck_fall = ~sck_sync[SYNC_STAGES-1] & sck_q;
  assign cs_rise  = cs_sync[SYNC_STAGES-1] & ~cs_q;
  assign cs_fall  = ~cs_sync[SYNC_STAGES-1] & cs_q;

  // Mode 0, MSB first
  always_ff @(posedge CLK) begin
    if (rst) begin
      tx_reg      <= '0;
      word_strobe <= 1'b0;
    end else begin
      word_strobe <= cs_rise;
      if (cs_fall) tx_reg <= word_tx;  // Reply goes out this frame
      else if (sck_fall && !cs_q) tx_reg <= {tx_reg[WORD_W-2:0], 1'b0};
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_q) rx_reg <= {rx_reg[WORD_W-2:0], copi_sync[SYNC_STAGES-1]};
  end

  assign word_rx = rx_reg;
  assign cipo    = tx_reg[WORD_W-1];

endmodule

`default_nettype wire

//--- logic/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module command_decoder (
  input  wire logic                              CLK,
  input  wire logic                              rst,
  input  wire motion_pkg::word_t                 word_rx,
  input  wire logic                              word_strobe,
  output motion_pkg::word_t                      word_tx,
  input  wire logic signed [motion_pkg::COUNT_W-1:0] count,
  output logic                                   enable,
  output motion_pkg::step_mode_t                 step_mode,
  output logic [motion_pkg::DIV_W-1:0]           clk_divisor,
  move_if.producer                               mv
);
  import motion_pkg::*;

  cmd_t                     hdr;        // Header of command in progress
  logic [1:0]               word_idx;   // Next word of a move
  logic                     in_move;
  cmd_t                     rx_cmd;
  move_t                    rec;
  logic signed [COUNT_W-1:0] count_snap;

  assign in_move = (hdr == CMD_COORDINATED_STEP);
  assign rx_cmd  = word_rx[63:56];

  always_ff @(posedge CLK) begin
    if (rst) begin
      hdr         <= '0;
      word_idx    <= '0;
      enable      <= 1'b0;
      step_mode   <= FULL_STEP;
      clk_divisor <= 8'd40;
      word_tx     <= '0;
      mv.push     <= 1'b0;
    end else begin
      mv.push <= 1'b0;
      if (word_strobe) begin
        word_tx <= '0;  // Most replies are empty
        if (!in_move) begin
          hdr      <= rx_cmd;
          word_idx <= 2'd1;
          case (rx_cmd)
            CMD_MOTOR_ENABLE: enable      <= word_rx[0];
            CMD_CLK_DIVISOR:  clk_divisor <= word_rx[DIV_W-1:0];
            CMD_MICROSTEPS:   step_mode   <= step_mode_t'(word_rx[0]);
            CMD_API_VERSION:  word_tx     <= {40'd0, VERSION_MAJOR, VERSION_MINOR,
                                              VERSION_PATCH};
            default: ;
          endcase
        end else begin
          word_idx <= word_idx + 2'd1;
          if (word_idx == 2'd2) word_tx <= count_snap;  // Encoder at move start
          if (word_idx == 2'd3) begin
            mv.push <= ~mv.full;  // Dropped when the queue is full
            hdr     <= '0;
          end
        end
      end
    end
  end

  // Move fields collect as the words arrive
  always_ff @(posedge CLK) begin
    if (word_strobe) begin
      if (!in_move) begin
        rec.dir    <= word_rx[0];
        count_snap <= count;
      end else begin
        case (word_idx)
          2'd1:    rec.duration  <= word_rx;
          2'd2:    rec.increment <= word_rx;
          default: rec.accel     <= word_rx;
        endcase
      end
    end
  end

  assign mv.push_move = rec;

endmodule

`default_nettype wire

//--- logic/move_queue.sv
`timescale 1ns/1ps
`default_nettype none

module move_queue #(
  parameter int MOVE_DEPTH = 4
) (
  input wire logic CLK,
  input wire logic rst,
  move_if.store    mv
);
  import motion_pkg::*;

  localparam int AW = $clog2(MOVE_DEPTH);

  move_t       mem [MOVE_DEPTH];
  logic [AW:0] wr_ptr;   // Extra bit tells full from empty
  logic [AW:0] rd_ptr;

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (mv.push && !mv.full) wr_ptr <= wr_ptr + 1'b1;
      if (mv.pop && !mv.empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (mv.push && !mv.full) mem[wr_ptr[AW-1:0]] <= mv.push_move;
  end

  assign mv.level = wr_ptr - rd_ptr;
  assign mv.full  = (mv.level == (AW+1)'(MOVE_DEPTH));
  assign mv.empty = (mv.level == '0);
  assign mv.head  = mem[rd_ptr[AW-1:0]];  // Oldest entry

endmodule

`default_nettype wire

//--- logic/dda_step_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dda_step_gen (
  input  wire logic                        CLK,
  input  wire logic                        rst,
  input  wire logic [motion_pkg::DIV_W-1:0] clk_divisor,
  move_if.consumer                         mv,
  output logic                             step,
  output logic                             dir,
  output logic                             move_done
);
  import motion_pkg::*;

  logic                busy;        // Move loaded and running
  logic [DIV_W-1:0]    div_cnt;     // Cycles to next tick
  logic [63:0]         ticks_left;
  logic signed [63:0]  acc;         // Substep position, 32.32
  logic signed [63:0]  acc_next;
  logic signed [63:0]  inc;
  logic signed [63:0]  accel;
  logic                tick;

  assign tick   = busy && (div_cnt == '0);
  assign mv.pop = ~busy & ~mv.empty;
  assign step   = (acc >= STEP_ONE);  // Crossed on the previous tick

  always_comb begin
    acc_next = acc;
    if (step) acc_next = acc_next - STEP_ONE;
    if (tick) acc_next = acc_next + inc;
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      busy       <= 1'b0;
      div_cnt    <= '0;
      ticks_left <= '0;
      acc        <= '0;
      dir        <= 1'b0;
      move_done  <= 1'b0;
    end else if (mv.pop) begin
      busy       <= 1'b1;
      div_cnt    <= clk_divisor;
      ticks_left <= mv.head.duration;
      acc        <= '0;   // Fresh start per move
      dir        <= mv.head.dir;
    end else begin
      acc <= acc_next;
      if (tick) begin
        div_cnt <= clk_divisor;
        if (ticks_left == '0) begin
          busy      <= 1'b0;
          move_done <= ~move_done;
        end else begin
          ticks_left <= ticks_left - 64'd1;
        end
      end else if (busy) begin
        div_cnt <= div_cnt - 1'b1;
      end
    end
  end

  // Velocity ramps once per tick
  always_ff @(posedge CLK) begin
    if (mv.pop) begin
      inc   <= mv.head.increment;
      accel <= mv.head.accel;
    end else if (tick) begin
      inc <= inc + accel;
    end
  end

endmodule

`default_nettype wire

//--- logic/phase_driver.sv
`timescale 1ns/1ps
`default_nettype none

module phase_driver (
  input  wire logic                   CLK,
  input  wire logic                   rst,
  input  wire logic                   step,
  input  wire logic                   dir,
  input  wire logic                   enable,
  input  wire motion_pkg::step_mode_t step_mode,
  output logic                        phase_a1,
  output logic                        phase_a2,
  output logic                        phase_b1,
  output logic                        phase_b2
);
  import motion_pkg::*;

  logic [2:0] seq_idx;
  logic [2:0] delta;
  logic [3:0] pattern;  // {a1, a2, b1, b2}

  assign delta = (step_mode == FULL_STEP) ? 3'd2 : 3'd1;

  always_ff @(posedge CLK) begin
    if (rst) seq_idx <= '0;
    else if (step) seq_idx <= dir ? seq_idx + delta : seq_idx - delta;
  end

  // Half-step table, even entries drive both coils
  always_comb begin
    case (seq_idx)
      3'd0: pattern = 4'b1010;  // A+ B+
      3'd1: pattern = 4'b0010;
      3'd2: pattern = 4'b0110;  // A- B+
      3'd3: pattern = 4'b0100;
      3'd4: pattern = 4'b0101;  // A- B-
      3'd5: pattern = 4'b0001;
      3'd6: pattern = 4'b1001;  // A+ B-
      default: pattern = 4'b1000;
    endcase
  end

  // Coils released while disabled
  assign {phase_a1, phase_a2, phase_b1, phase_b2} = enable ? pattern : 4'b0000;

endmodule

`default_nettype wire

//--- logic/quad_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module quad_encoder #(
  parameter int SYNC_STAGES = 2
) (
  input  wire logic                               CLK,
  input  wire logic                               rst,
  input  wire logic                               a,
  input  wire logic                               b,
  output logic signed [motion_pkg::COUNT_W-1:0]   count,
  output logic                                    fault
);

  logic [SYNC_STAGES-1:0] a_sync;
  logic [SYNC_STAGES-1:0] b_sync;
  logic                   a_s;
  logic                   b_s;
  logic                   a_q;
  logic                   b_q;

  assign a_s = a_sync[SYNC_STAGES-1];
  assign b_s = b_sync[SYNC_STAGES-1];

  always_ff @(posedge CLK) begin
    if (rst) begin
      a_sync <= '0;
      b_sync <= '0;
      a_q    <= 1'b0;
      b_q    <= 1'b0;
      count  <= '0;
      fault  <= 1'b0;
    end else begin
      a_sync <= {a_sync[SYNC_STAGES-2:0], a};
      b_sync <= {b_sync[SYNC_STAGES-2:0], b};
      a_q    <= a_s;
      b_q    <= b_s;
      if ((a_s != a_q) && (b_s != b_q)) begin
        fault <= 1'b1;  // Lost a state, sticky
      end else if ((a_s != a_q) || (b_s != b_q)) begin
        // x4 decode, up when A leads
        if (a_s ^ b_q) count <= count + 64'sd1;
        else count <= count - 64'sd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/motion_top.sv
`timescale 1ns/1ps
`default_nettype none

module motion_top #(
  parameter int MOVE_DEPTH  = 4,
  parameter int SYNC_STAGES = 2
) (
  input  wire logic CLK,
  input  wire logic rst,
  input  wire logic sck,
  input  wire logic cs,
  input  wire logic copi,
  input  wire logic enc_a,
  input  wire logic enc_b,
  output logic      cipo,
  output logic      phase_a1,
  output logic      phase_a2,
  output logic      phase_b1,
  output logic      phase_b2,
  output logic      buffer_ready,
  output logic      move_done,
  output logic      encoder_fault
);
  import motion_pkg::*;

  word_t                     word_rx;
  word_t                     word_tx;
  logic                      word_strobe;
  logic signed [COUNT_W-1:0] count;
  logic                      enable;
  step_mode_t                step_mode;
  logic [DIV_W-1:0]          clk_divisor;
  logic                      step;
  logic                      dir;

  move_if #(.MOVE_DEPTH(MOVE_DEPTH)) mv ();

  spi_word_port #(.SYNC_STAGES(SYNC_STAGES)) spi_word_port_inst (
    .CLK, .rst, .sck, .cs, .copi, .cipo, .word_rx, .word_strobe, .word_tx
  );

  command_decoder command_decoder_inst (
    .CLK, .rst, .word_rx, .word_strobe, .word_tx, .count,
    .enable, .step_mode, .clk_divisor, .mv(mv.producer)
  );

  move_queue #(.MOVE_DEPTH(MOVE_DEPTH)) move_queue_inst (.CLK, .rst, .mv(mv.store));

  dda_step_gen dda_step_gen_inst (
    .CLK, .rst, .clk_divisor, .mv(mv.consumer), .step, .dir, .move_done
  );

  phase_driver phase_driver_inst (
    .CLK, .rst, .step, .dir, .enable, .step_mode,
    .phase_a1, .phase_a2, .phase_b1, .phase_b2
  );

  quad_encoder #(.SYNC_STAGES(SYNC_STAGES)) quad_encoder_inst (
    .CLK, .rst, .a(enc_a), .b(enc_b), .count, .fault(encoder_fault)
  );

  assign buffer_ready = ~mv.full;  // Host may send another move

endmodule

`default_nettype wire

//--- bench/motion_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module motion_assertions #(
  parameter bit CHECK_QUEUE = 1'b1,
  parameter bit CHECK_STEP  = 1'b1
) (
  input wire logic CLK,
  input wire logic rst,
  input wire logic push,
  input wire logic full,
  input wire logic pop,
  input wire logic empty,
  input wire logic step,
  input wire logic dir
);

  int fail_count = 0;  // Failed assertions so far

  if (CHECK_QUEUE) begin : g_queue
    push_not_full: assert property (@(posedge CLK) disable iff (rst) push |-> !full)
      else begin
        fail_count++;
        $error("push while the move queue is full");
      end

    // Pop only from a filled queue, and only for one cycle
    pop_not_empty: assert property (
      @(posedge CLK) disable iff (rst) pop |-> !empty ##1 !pop
    ) else begin
        fail_count++;
        $error("pop while the move queue is empty or held for more than one cycle");
      end
  end

  if (CHECK_STEP) begin : g_step
    step_single: assert property (@(posedge CLK) disable iff (rst) step |=> !step)
      else begin
        fail_count++;
        $error("step high on two consecutive cycles");
      end

    dir_stable: assert property (@(posedge CLK) disable iff (rst) step |-> $stable(dir))
      else begin
        fail_count++;
        $error("dir changed during a step");
      end
  end

endmodule

bind move_queue motion_assertions #(.CHECK_QUEUE(1'b1), .CHECK_STEP(1'b0)) queue_checks (
  .CLK(CLK), .rst(rst), .push(mv.push), .full(mv.full),
  .pop(mv.pop), .empty(mv.empty), .step(1'b0), .dir(1'b0)
);

bind dda_step_gen motion_assertions #(.CHECK_QUEUE(1'b0), .CHECK_STEP(1'b1)) step_checks (
  .CLK(CLK), .rst(rst), .push(1'b0), .full(1'b0),
  .pop(1'b0), .empty(1'b1), .step(step), .dir(dir)
);

`default_nettype wire

//--- bench/motion_tb.sv
`timescale 1ns/1ps
`default_nettype none

module motion_tb;
  import motion_pkg::*;

  localparam int TIMEOUT = 200000;  // Cycles per wait loop

  logic CLK;
  logic rst;
  logic sck;
  logic cs;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic buffer_ready;
  logic move_done;
  logic encoder_fault;

  logic [63:0] last_reply;
  logic        model_en;
  logic        model_half;
  int          move_word;    // Next word of a move, 0 when none
  logic        move_dir;
  logic [63:0] move_dur;
  logic [63:0] move_inc;
  int          pos;          // Running phase position
  int          done_cnt;
  logic        done_q;

  motion_top motion_top_inst (
    .CLK, .rst, .sck, .cs, .copi, .enc_a, .enc_b, .cipo,
    .phase_a1, .phase_a2, .phase_b1, .phase_b2,
    .buffer_ready, .move_done, .encoder_fault
  );

  always #5 CLK = ~CLK;

  // Count move_done toggles
  always @(posedge CLK) begin
    done_q <= move_done;
    if (!rst && (move_done != done_q)) done_cnt <= done_cnt + 1;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  function automatic int bound_failures();
    return motion_top_inst.move_queue_inst.queue_checks.fail_count +
           motion_top_inst.dda_step_gen_inst.step_checks.fail_count;
  endfunction

  // Stop at the first failed bound assertion
  always @(posedge CLK) begin
    if (bound_failures() != 0) fail_run("A bound assertion on the queue or step generator failed");
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  // Reference DDA, one step per STEP_ONE of accumulated velocity
  function automatic int dda_steps(input logic [63:0] dur, input logic signed [63:0] inc,
                                   input logic signed [63:0] accel);
    logic signed [63:0] acc;
    logic signed [63:0] one;
    int                 steps;
    acc   = 0;
    one   = 64'sh1_0000_0000;
    steps = 0;
    for (longint t = 0; t <= longint'(dur); t++) begin
      if (acc >= one) begin
        acc = acc - one;
        steps++;
      end
      acc = acc + inc;
      inc = inc + accel;
    end
    if (acc >= one) steps++;  // Last step lands after the final tick
    return steps;
  endfunction

  function automatic logic [3:0] phase_to_index(input logic [3:0] p);
    case (p)
      4'b1010: return 4'd0;
      4'b0010: return 4'd1;
      4'b0110: return 4'd2;
      4'b0100: return 4'd3;
      4'b0101: return 4'd4;
      4'b0001: return 4'd5;
      4'b1001: return 4'd6;
      4'b1000: return 4'd7;
      default: return 4'hf;
    endcase
  endfunction

  // Track settings and moves the way the decoder should see them
  task automatic track_word(input logic [63:0] w);
    int steps;
    if (move_word == 0) begin
      case (w[63:56])
        8'h01: begin
          move_word = 1;
          move_dir  = w[0];
        end
        8'h0a: model_en = w[0];
        8'h0c: model_half = w[0];
        default: ;
      endcase
    end else begin
      if (move_word == 1) move_dur = w;
      if (move_word == 2) move_inc = w;
      move_word++;
      if (move_word == 4) begin
        steps     = dda_steps(move_dur, move_inc, w) * (model_half ? 1 : 2);
        pos       = move_dir ? pos + steps : pos - steps;
        move_word = 0;
      end
    end
  endtask

  // SPI mode 0 frame, MSB first
  task automatic send_frame(input logic [63:0] tx);
    cs = 1'b0;
    wait_cycles(4);
    for (int i = 63; i >= 0; i--) begin
      copi = tx[i];
      wait_cycles(4);
      last_reply[i] = cipo;
      sck = 1'b1;
      wait_cycles(4);
      sck = 1'b0;
    end
    wait_cycles(4);
    cs = 1'b1;
    wait_cycles(10);  // Idle gap
    track_word(tx);
  endtask

  task automatic encoder_steps(input int n, input logic up);
    repeat (n) begin
      if ((enc_a == enc_b) == up) enc_a = ~enc_a;
      else enc_b = ~enc_b;
      wait_cycles(4);
    end
  endtask

  task automatic wait_ready(input logic level);
    int t;
    t = 0;
    while (buffer_ready != level) begin
      wait_cycles(1);
      t++;
      if (t > TIMEOUT) fail_run("buffer_ready never reached the expected level");
    end
  endtask

  task automatic check_phases(input logic [63:0] exp_idx, input int exp_done);
    int         t;
    logic [3:0] idx;
    t = 0;
    while (done_cnt < exp_done) begin
      wait_cycles(1);
      assert (model_en || {phase_a1, phase_a2, phase_b1, phase_b2} == 4'b0000)
        else fail_run("Phase outputs driven while the motor is disabled");
      t++;
      if (t > TIMEOUT) fail_run("Timed out waiting for the queue to drain");
    end
    wait_cycles(8);  // Last step and phase update
    assert (done_cnt == exp_done)
      else fail_run($sformatf("ERR move_done toggles got %h expected %h", done_cnt, exp_done));
    idx = phase_to_index({phase_a1, phase_a2, phase_b1, phase_b2});
    if (model_en) begin
      assert (idx == {1'b0, exp_idx[2:0]})
        else fail_run($sformatf("ERR phase index got %h expected %h", idx, exp_idx[2:0]));
      assert (exp_idx[2:0] == 3'(pos))
        else fail_run($sformatf("ERR model index got %h trace %h", 3'(pos), exp_idx[2:0]));
    end else begin
      assert (idx == 4'hf && {phase_a1, phase_a2, phase_b1, phase_b2} == 4'b0000)
        else fail_run("Phase outputs driven while the motor is disabled");
    end
  endtask

  initial begin
    #20ms;
    $display("Simulation ran past its time limit");
    $display("Errors found");
    $fatal(1);
  end

  initial begin
    int          fd;
    string       line;
    byte         kind;
    logic [63:0] f1;
    logic [63:0] f2;
    int          t;
    CLK = 1'b0;
    rst = 1'b1;
    sck = 1'b0;
    cs  = 1'b1;  // Bus idle
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    done_cnt = 0;
    done_q = 1'b0;
    model_en = 1'b0;
    model_half = 1'b0;
    move_word = 0;
    pos = 0;
    last_reply = '0;
    repeat (4) @(posedge CLK);
    #1 rst = 1'b0;
    wait_cycles(2);
    assert (buffer_ready && !move_done && !cipo && !encoder_fault)
      else fail_run("Outputs not at their reset values");
    assert ({phase_a1, phase_a2, phase_b1, phase_b2} == 4'b0000)
      else fail_run("Phases active after reset");

    fd = $fopen("bench/motion_trace.txt", "r");
    if (fd == 0) fail_run("Cannot open the trace file");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) continue;
      if (line.len() < 2 || line[0] == "#") continue;
      f1 = '0;
      f2 = '0;
      void'($sscanf(line, "%c %h %h", kind, f1, f2));
      case (kind)
        "W": send_frame(f1);
        "R": assert (last_reply == f1)
          else fail_run($sformatf("ERR cipo reply got %h expected %h", last_reply, f1));
        "E": encoder_steps(int'(f1), f2[0]);
        "P": check_phases(f1, int'(f2));
        "B": wait_ready(f1[0]);
        default: fail_run("Unknown line kind in the trace");
      endcase
    end
    $fclose(fd);

    // Both encoder inputs change at once
    enc_a = ~enc_a;
    enc_b = ~enc_b;
    t = 0;
    while (!encoder_fault) begin
      wait_cycles(1);
      t++;
      if (t > 100) fail_run("encoder_fault not set by a simultaneous A/B change");
    end

    if (bound_failures() == 0) begin
      $display("No errors");
      $finish;
    end else begin
      fail_run("A bound assertion on the queue or step generator failed");
    end
  end

endmodule

`default_nettype wire

//--- bench/motion_trace.txt
# W word 0 | R expected reply of last frame 0 | E steps up(1)/down(0)
# P phase index, move_done count | B buffer_ready level 0
W fe00000000000000 0
W 0a00000000000001 0
R 0000000000000100 0
W 0b00000000000003 0
R 0000000000000000 0
E 000000000000000a 1
E 0000000000000003 0
W 0100000000000001 0
R 0000000000000000 0
W 0000000000000009 0
W 0000000080000000 0
W 0000000000000000 0
R 0000000000000007 0
P 0000000000000002 1
W 0100000000000000 0
W 0000000000000003 0
W 00000000c0000000 0
W 0000000000000000 0
R 0000000000000007 0
P 0000000000000004 2
W 0c00000000000001 0
R 0000000000000000 0
E 0000000000000010 0
W 0100000000000001 0
W 0000000000000007 0
W 0000000020000000 0
W 0000000010000000 0
R fffffffffffffff7 0
P 0000000000000006 3
W 0b000000000000ff 0
W 0100000000000001 0
W 0000000000000027 0
W 0000000040000000 0
W 0000000000000000 0
W 0100000000000000 0
W 0000000000000003 0
W 0000000080000000 0
W 0000000000000000 0
W 0100000000000000 0
W 0000000000000003 0
W 0000000080000000 0
W 0000000000000000 0
W 0100000000000001 0
W 0000000000000003 0
W 0000000080000000 0
W 0000000000000000 0
W 0100000000000000 0
W 0000000000000003 0
W 0000000080000000 0
W 0000000000000000 0
B 0000000000000000 0
B 0000000000000001 0
P 0000000000000004 8
W 0a00000000000000 0
W 0100000000000001 0
W 0000000000000004 0
W 0000000080000000 0
W 0000000000000000 0
P 0000000000000000 9
W 0a00000000000001 0
P 0000000000000006 9

//--- sources.f
logic/motion_pkg.sv
logic/move_if.sv
logic/spi_word_port.sv
logic/command_decoder.sv
logic/move_queue.sv
logic/dda_step_gen.sv
logic/phase_driver.sv
logic/quad_encoder.sv
logic/motion_top.sv
bench/motion_assertions.sv
bench/motion_tb.sv

//--- Bender.yml
package:
  name: motion_ctrl

sources:
  - files:
      - logic/motion_pkg.sv
      - logic/move_if.sv
      - logic/spi_word_port.sv
      - logic/command_decoder.sv
      - logic/move_queue.sv
      - logic/dda_step_gen.sv
      - logic/phase_driver.sv
      - logic/quad_encoder.sv
      - logic/motion_top.sv
  - target: simulation
    files:
      - bench/motion_assertions.sv
      - bench/motion_tb.sv
